//--- hw/fetch_pkg.sv
//==================================================
// fetch_pkg
// sizes, opcode encoding and the structs passed
// between fetch, fetch buffer and decode
//==================================================
package fetch_pkg;

   // datapath widths
   localparam int PC_W    = 16;
   localparam int INSTR_W = 16;
   localparam int IMM_W   = 12;

   // instruction memory geometry
   localparam int MEM_WORDS   = 256;
   localparam int MEM_AW      = $clog2(MEM_WORDS);
   localparam int LINE_BYTES  = 8;
   localparam int LINE_BITS   = $clog2(LINE_BYTES);
   localparam int LINE_TAG_W  = PC_W - LINE_BITS;
   localparam int MISS_CYCLES = 3;
   localparam int MISS_W      = $clog2(MISS_CYCLES + 1);

   // fetch buffer
   localparam int BUF_DEPTH = 2;
   localparam int BUF_PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

   // loop counter, loaded from imm[7:0]
   localparam int CNT_W = 8;

   // opcode in instr[15:12], unlisted codes act as alu
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ALU  = 4'd1,
      OP_J    = 4'd2,
      OP_LDC  = 4'd3,
      OP_DBNZ = 4'd4,
      OP_HALT = 4'd15
   } opcode_e;

   typedef struct packed {
      logic [PC_W-1:0]    pc;
      logic [INSTR_W-1:0] instr;
   } fetch_word_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] target;
   } redirect_t;

   typedef struct packed {
      logic [PC_W-1:0]    pc;
      logic [INSTR_W-1:0] instr;
   } retire_t;

endpackage

//--- hw/inst_mem.sv
`timescale 1ns/1ps
//==================================================
// inst_mem
// word-addressed instruction memory with a load
// port; models a one-line cache, so an access in
// the same 8-byte line hits and any other access
// waits MISS_CYCLES extra cycles
//==================================================
module inst_mem (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           load_en,
   input  logic [fetch_pkg::MEM_AW-1:0]   load_addr,
   input  logic [fetch_pkg::INSTR_W-1:0]  load_data,
   input  logic                           rd_en,
   input  logic [fetch_pkg::PC_W-1:0]     addr,
   output logic [fetch_pkg::INSTR_W-1:0]  instr,
   output logic                           done,
   output logic                           busy
);

   // word array
   logic [fetch_pkg::INSTR_W-1:0] mem [fetch_pkg::MEM_WORDS];

   // last line seen, plus its valid bit
   logic [fetch_pkg::LINE_TAG_W-1:0] tag_q;
   logic                             tag_valid_q;

   // remaining wait cycles for the access in flight
   logic [fetch_pkg::MISS_W-1:0] wait_q;

   logic req;
   logic hit;

   // a request is only taken while idle
   assign req = rd_en && !busy;

   // same line as the previous access
   assign hit = tag_valid_q &&
                (addr[fetch_pkg::PC_W-1:fetch_pkg::LINE_BITS] == tag_q);

   // access ends once the wait count drains
   assign done = busy && (wait_q == '0);

   // load port writes straight into the array
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // registered read, held until the next request
   // byte address, so word index drops bit 0
   always_ff @(posedge clk) begin
      if (req) begin
         instr <= mem[addr[fetch_pkg::MEM_AW:1]];
      end
   end

   // latency control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy        <= 1'b0;
         wait_q      <= '0;
         tag_q       <= '0;
         tag_valid_q <= 1'b0;
      end else if (req) begin
         busy        <= 1'b1;
         // hit answers next cycle, miss adds the penalty
         wait_q      <= hit ? '0 : fetch_pkg::MISS_CYCLES[fetch_pkg::MISS_W-1:0];
         tag_q       <= addr[fetch_pkg::PC_W-1:fetch_pkg::LINE_BITS];
         tag_valid_q <= 1'b1;
      end else if (done) begin
         busy <= 1'b0;
      end else if (busy) begin
         wait_q <= wait_q - 1'b1;
      end
   end

   // fetch has to hold the address for the whole access
   addr_stable_a : assert property (
      @(posedge clk) disable iff (!rst_n) busy |-> $stable(addr)
   );

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
//==================================================
// fetch_unit
// pc register and next-pc selection; pc steps by 2,
// holds through memory stalls, keeps a redirect that
// lands mid-access until the access is done, and
// freezes on halt
//==================================================
module fetch_unit (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           start,
   input  logic                           full,
   input  logic                           done,
   input  logic [fetch_pkg::INSTR_W-1:0]  instr,
   input  fetch_pkg::redirect_t           redirect,
   input  logic                           halted,
   output logic                           rd_en,
   output logic [fetch_pkg::PC_W-1:0]     addr,
   output logic                           push,
   output fetch_pkg::fetch_word_t         word
);

   logic [fetch_pkg::PC_W-1:0] pc_q;
   logic [fetch_pkg::PC_W-1:0] pc_next;
   logic [fetch_pkg::PC_W-1:0] pc_plus2;

   // one access outstanding at most
   logic in_flight_q;

   // access in flight belongs to the old path
   // also marks pend_target_q as the next pc
   logic                       stale_q;
   logic [fetch_pkg::PC_W-1:0] pend_target_q;

   logic latch_redirect;

   assign pc_plus2 = pc_q + 2'd2;

   // memory address is the pc itself, held while busy
   assign addr = pc_q;

   // redirect that meets an access on the old path
   // either still in memory or leaving this cycle
   assign latch_redirect = redirect.valid && ((in_flight_q && !done) || rd_en);

   // new request when idle and running with buffer room
   assign rd_en = start && !halted && !in_flight_q && !full;

   // deliver unless the word is on a dead path
   assign push = done && !stale_q && !redirect.valid && !halted;

   always_comb begin
      word.pc    = pc_q;
      word.instr = instr;
   end

   // next pc
   always_comb begin
      pc_next = pc_q;
      if (halted) begin
         // frozen
         pc_next = pc_q;
      end else if (redirect.valid && !latch_redirect) begin
         // nothing pending in memory, jump now
         pc_next = redirect.target;
      end else if (done && stale_q) begin
         // stall over, apply the latched target
         pc_next = pend_target_q;
      end else if (push) begin
         pc_next = pc_plus2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q        <= '0;
         in_flight_q <= 1'b0;
         stale_q     <= 1'b0;
      end else begin
         pc_q <= pc_next;
         if (rd_en) begin
            in_flight_q <= 1'b1;
         end else if (done) begin
            in_flight_q <= 1'b0;
         end
         if (latch_redirect) begin
            stale_q <= 1'b1;
         end else if (done) begin
            stale_q <= 1'b0;
         end
      end
   end

   // target held across the stall
   always_ff @(posedge clk) begin
      if (latch_redirect) begin
         pend_target_q <= redirect.target;
      end
   end

   // requests are gated by full, and only one is ever in flight
   no_push_full_a : assert property (
      @(posedge clk) disable iff (!rst_n) push |-> !full
   );

endmodule

//--- hw/fetch_buffer.sv
`timescale 1ns/1ps
//==================================================
// fetch_buffer
// small in-order queue between fetch and decode,
// emptied on a redirect
//==================================================
module fetch_buffer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    push,
   input  fetch_pkg::fetch_word_t  word_in,
   input  logic                    pop,
   input  logic                    flush,
   output fetch_pkg::fetch_word_t  head,
   output logic                    nonempty,
   output logic                    full
);

   fetch_pkg::fetch_word_t entries [fetch_pkg::BUF_DEPTH];

   logic [fetch_pkg::BUF_PTR_W-1:0] wr_ptr_q;
   logic [fetch_pkg::BUF_PTR_W-1:0] rd_ptr_q;
   logic [fetch_pkg::BUF_CNT_W-1:0] count_q;

   logic do_push;
   logic do_pop;

   // flush wins over everything in its cycle
   assign do_push = push && !flush;
   assign do_pop  = pop && !flush;

   assign head     = entries[rd_ptr_q];
   assign nonempty = (count_q != '0);
   assign full     = (count_q == fetch_pkg::BUF_DEPTH[fetch_pkg::BUF_CNT_W-1:0]);

   // storage, no reset needed
   always_ff @(posedge clk) begin
      if (do_push) begin
         entries[wr_ptr_q] <= word_in;
      end
   end

   // pointers wrap at BUF_DEPTH
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == fetch_pkg::BUF_PTR_W'(fetch_pkg::BUF_DEPTH - 1)) ?
                        '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == fetch_pkg::BUF_PTR_W'(fetch_pkg::BUF_DEPTH - 1)) ?
                        '0 : rd_ptr_q + 1'b1;
         end
         // push and pop together leave the count alone
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // decode only pops a valid head
   no_pop_empty_a : assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> nonempty
   );

   // fetch never pushes past the last slot
   no_overflow_a : assert property (
      @(posedge clk) disable iff (!rst_n) (push && !pop) |-> !full
   );

endmodule

//--- hw/decode_branch.sv
`timescale 1ns/1ps
//==================================================
// decode_branch
// decodes the control subset, keeps the loop
// counter, redirects fetch on taken branches and
// retires in program order until halt
//==================================================
module decode_branch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  fetch_pkg::fetch_word_t  head,
   input  logic                    nonempty,
   output logic                    pop,
   output fetch_pkg::redirect_t    redirect,
   output logic                    retire_valid,
   output fetch_pkg::retire_t      retire,
   output logic                    halted
);

   fetch_pkg::opcode_e op;

   logic [fetch_pkg::IMM_W-1:0] imm;
   logic [fetch_pkg::PC_W-1:0]  target;
   logic [fetch_pkg::CNT_W-1:0] cnt_q;
   logic [fetch_pkg::CNT_W-1:0] cnt_dec;
   logic                        taken;

   // opcode in the top nibble, imm below it
   assign op  = fetch_pkg::opcode_e'(head.instr[fetch_pkg::INSTR_W-1 -: 4]);
   assign imm = head.instr[fetch_pkg::IMM_W-1:0];

   // pc + 2 + 2 * signed(imm)
   assign target = head.pc + 2'd2 +
                   {{(fetch_pkg::PC_W - fetch_pkg::IMM_W - 1){imm[fetch_pkg::IMM_W-1]}},
                    imm, 1'b0};

   assign cnt_dec = cnt_q - 1'b1;

   // consume the head whenever one is there
   assign pop = nonempty && !halted;

   always_comb begin
      case (op)
         fetch_pkg::OP_J:    taken = 1'b1;
         // branch on the decremented value
         fetch_pkg::OP_DBNZ: taken = (cnt_dec != '0);
         default:            taken = 1'b0;
      endcase
   end

   // one-cycle redirect, also flushes the buffer
   always_comb begin
      redirect.valid  = pop && taken;
      redirect.target = target;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q        <= '0;
         retire_valid <= 1'b0;
         halted       <= 1'b0;
      end else begin
         retire_valid <= pop;
         if (pop) begin
            case (op)
               fetch_pkg::OP_LDC:  cnt_q  <= imm[fetch_pkg::CNT_W-1:0];
               fetch_pkg::OP_DBNZ: cnt_q  <= cnt_dec;
               // halt retires first, then stops decode
               fetch_pkg::OP_HALT: halted <= 1'b1;
               // nop and alu class retire with no effect
               default: ;
            endcase
         end
      end
   end

   // retire record, lines up with retire_valid
   always_ff @(posedge clk) begin
      if (pop) begin
         retire.pc    <= head.pc;
         retire.instr <= head.instr;
      end
   end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps
//==================================================
// fetch_top
// fetch front end: instruction memory, fetch unit,
// fetch buffer and decode/branch unit
//==================================================
module fetch_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           load_en,
   input  logic [fetch_pkg::MEM_AW-1:0]   load_addr,
   input  logic [fetch_pkg::INSTR_W-1:0]  load_data,
   input  logic                           start,
   output logic                           retire_valid,
   output fetch_pkg::retire_t             retire,
   output logic                           halted
);

   // fetch to memory
   logic                          mem_rd_en;
   logic [fetch_pkg::PC_W-1:0]    mem_addr;
   logic [fetch_pkg::INSTR_W-1:0] mem_instr;
   logic                          mem_done;

   // fetch to buffer to decode
   logic                          fetch_push;
   fetch_pkg::fetch_word_t        fetch_word;
   fetch_pkg::fetch_word_t        buf_head;
   logic                          buf_nonempty;
   logic                          buf_full;
   logic                          dec_pop;

   // decode back to fetch and buffer
   fetch_pkg::redirect_t          redirect;

   inst_mem inst_mem_inst (
      .clk(clk), .rst_n(rst_n),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .rd_en(mem_rd_en), .addr(mem_addr),
      .instr(mem_instr), .done(mem_done), .busy()
   );

   fetch_unit fetch_unit_inst (
      .clk(clk), .rst_n(rst_n), .start(start), .full(buf_full),
      .done(mem_done), .instr(mem_instr), .redirect(redirect), .halted(halted),
      .rd_en(mem_rd_en), .addr(mem_addr), .push(fetch_push), .word(fetch_word)
   );

   fetch_buffer fetch_buffer_inst (
      .clk(clk), .rst_n(rst_n),
      .push(fetch_push), .word_in(fetch_word),
      .pop(dec_pop), .flush(redirect.valid),
      .head(buf_head), .nonempty(buf_nonempty), .full(buf_full)
   );

   decode_branch decode_branch_inst (
      .clk(clk), .rst_n(rst_n), .head(buf_head), .nonempty(buf_nonempty),
      .pop(dec_pop), .redirect(redirect),
      .retire_valid(retire_valid), .retire(retire), .halted(halted)
   );

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
//==================================================
// fetch_tb
// loads small programs into the fetch front end,
// runs each to halt and compares the retire stream
// against an ISA model of the control subset
//==================================================
module fetch_tb;

   localparam int CLK_PERIOD      = 40;
   localparam int LOAD_CYCLES     = fetch_pkg::MEM_WORDS + 4;
   localparam int MARGIN_CYCLES   = 100;
   localparam int MODEL_MAX_STEPS = 4000;

   logic                             clk;
   logic                             rst_n;
   logic                             load_en;
   logic [fetch_pkg::MEM_AW-1:0]     load_addr;
   logic [fetch_pkg::INSTR_W-1:0]    load_data;
   logic                             start;
   logic                             retire_valid;
   fetch_pkg::retire_t               retire;
   logic                             halted;

   // testbench copy of the program
   logic [fetch_pkg::INSTR_W-1:0] model_mem [fetch_pkg::MEM_WORDS];

   // {pc, instr} records, expected and seen
   logic [31:0] exp_q [$];
   logic [31:0] act_q [$];

   string  test_name;
   int     err_count;
   int     test_count;
   int     fail_count;
   logic   mon_en;
   logic   halt_seen;
   time    deadline;
   integer seed;

   fetch_top fetch_top_inst (
      .clk(clk), .rst_n(rst_n),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .start(start),
      .retire_valid(retire_valid), .retire(retire), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         err_count++;
      end
   endtask

   // random alu-class word, control opcodes remapped to alu
   function automatic logic [15:0] alu_word(input logic [31:0] r);
      logic [3:0] op;
      op = r[15:12];
      if (op == fetch_pkg::OP_J || op == fetch_pkg::OP_LDC ||
          op == fetch_pkg::OP_DBNZ || op == fetch_pkg::OP_HALT) begin
         op = fetch_pkg::OP_ALU;
      end
      return {op, r[11:0]};
   endfunction

   // unused words are alu ops tagged with their index
   task automatic fill_background();
      for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
         model_mem[fetch_pkg::MEM_AW'(i)] = {8'h10, 8'(i)};
      end
   endtask

   task automatic place(input int byte_addr, input logic [15:0] w);
      model_mem[fetch_pkg::MEM_AW'(byte_addr / 2)] = w;
   endtask

   // ISA model: walks the program and queues each retire
   function automatic int run_model();
      logic [15:0] pc;
      logic [15:0] instr;
      logic [15:0] target;
      logic [11:0] imm;
      logic [7:0]  cnt;
      logic        halt_hit;
      int          steps;
      exp_q.delete();
      pc       = 16'd0;
      cnt      = 8'd0;
      halt_hit = 1'b0;
      steps    = 0;
      while (!halt_hit && steps < MODEL_MAX_STEPS) begin
         instr  = model_mem[pc[fetch_pkg::MEM_AW:1]];
         imm    = instr[11:0];
         // pc + 2 + 2 * signed imm
         target = pc + 16'd2 + 16'(2 * $signed(imm));
         exp_q.push_back({pc, instr});
         steps++;
         case (instr[15:12])
            fetch_pkg::OP_J: pc = target;
            fetch_pkg::OP_LDC: begin
               cnt = imm[7:0];
               pc  = pc + 16'd2;
            end
            fetch_pkg::OP_DBNZ: begin
               cnt = cnt - 8'd1;
               pc  = (cnt != 8'd0) ? target : pc + 16'd2;
            end
            fetch_pkg::OP_HALT: halt_hit = 1'b1;
            default: pc = pc + 16'd2;
         endcase
      end
      return steps;
   endfunction

   // one word per cycle through the load port
   task automatic load_program();
      for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
         @(posedge clk);
         #2;
         load_en   = 1'b1;
         load_addr = fetch_pkg::MEM_AW'(i);
         load_data = model_mem[fetch_pkg::MEM_AW'(i)];
      end
      @(posedge clk);
      #2;
      load_en = 1'b0;
   endtask

   task automatic run_test(input string name, input int hold_cycles);
      int          steps;
      int          rd_seen;
      logic [15:0] halt_pc;
      steps     = run_model();
      halt_pc   = exp_q[exp_q.size() - 1][31:16];
      test_name = name;
      rd_seen   = 0;
      // budget per retire covers a full miss plus handoff
      deadline = $time + time'((LOAD_CYCLES + steps * (fetch_pkg::MISS_CYCLES + 4) +
                                hold_cycles + MARGIN_CYCLES) * CLK_PERIOD);
      @(posedge clk);
      #2;
      rst_n  = 1'b0;
      start  = 1'b0;
      mon_en = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      load_program();
      act_q.delete();
      halt_seen = 1'b0;
      mon_en    = 1'b1;
      start     = 1'b1;
      while (!halted) @(negedge clk);
      // fetch must stay idle and parked after halt
      repeat (hold_cycles) begin
         @(negedge clk);
         if (fetch_top_inst.mem_rd_en) begin
            rd_seen++;
         end
      end
      @(posedge clk);
      #2;
      mon_en = 1'b0;
      start  = 1'b0;
      check_value(name, 32'(exp_q.size()), 32'(act_q.size()));
      check_value(name, 32'd1, {31'd0, halted});
      check_value(name, 32'd0, 32'(rd_seen));
      // pc parks on the word after halt
      check_value(name, {16'd0, halt_pc + 16'd2}, {16'd0, fetch_top_inst.mem_addr});
   endtask

   // one summary line per test
   task automatic report_test(input string name, input int errs_before);
      test_count++;
      if (err_count == errs_before) begin
         $display("test %s passed, %0d retired", name, act_q.size());
      end else begin
         fail_count++;
         $display("test %s failed, %0d errors", name, err_count - errs_before);
      end
   endtask

   // monitor, compares every retire in order
   initial begin
      forever begin
         @(negedge clk);
         if (mon_en && retire_valid) begin
            if (halt_seen) begin
               $display("retire after halt in test %s, pc %h", test_name, retire.pc);
               err_count++;
            end else if (act_q.size() < exp_q.size()) begin
               check_value(test_name, exp_q[act_q.size()], {retire.pc, retire.instr});
            end else begin
               $display("extra retire in test %s, pc %h", test_name, retire.pc);
               err_count++;
            end
            act_q.push_back({retire.pc, retire.instr});
         end
         // halted rises with the halt retire itself
         if (mon_en && halted) begin
            halt_seen = 1'b1;
         end
      end
   end

   // watchdog, deadline armed by each test
   initial begin
      @(posedge clk);
      while (deadline == 0 || $time <= deadline) @(posedge clk);
      $display("watchdog timeout in test %s, the program never halted", test_name);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      int hits;
      int errs;
      rst_n      = 1'b0;
      start      = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      mon_en     = 1'b0;
      halt_seen  = 1'b0;
      deadline   = 0;
      err_count  = 0;
      test_count = 0;
      fail_count = 0;
      seed       = 32'hf302d5c1;

      // straight line, nop and alu then halt
      fill_background();
      for (int i = 0; i < 12; i++) begin
         place(2 * i, (i % 2 == 0) ? 16'h0000 : alu_word($random(seed)));
      end
      place(24, 16'hF000);
      errs = err_count;
      run_test("straight_line", 8);
      report_test("straight_line", errs);

      // forward jump from 0x04 over to 0x30
      fill_background();
      place(16'h00, 16'h1001);
      place(16'h02, 16'h1002);
      place(16'h04, 16'h2015);
      place(16'h30, 16'h1003);
      place(16'h32, 16'h0000);
      place(16'h34, 16'hF000);
      errs = err_count;
      run_test("forward_jump", 8);
      hits = 0;
      foreach (act_q[i]) begin
         if (act_q[i][31:16] >= 16'h0006 && act_q[i][31:16] < 16'h0030) begin
            hits++;
         end
      end
      check_value("forward_jump", 32'd0, 32'(hits));
      report_test("forward_jump", errs);

      // ldc 3 then dbnz back to the body at 0x04
      fill_background();
      place(16'h00, 16'h0000);
      place(16'h02, 16'h3003);
      place(16'h04, 16'h1111);
      place(16'h06, 16'h1222);
      place(16'h08, 16'h4FFD);
      place(16'h0A, 16'hF000);
      errs = err_count;
      run_test("dbnz_loop", 8);
      hits = 0;
      foreach (act_q[i]) begin
         if (act_q[i][31:16] == 16'h0004) begin
            hits++;
         end
      end
      check_value("dbnz_loop", 32'd3, 32'(hits));
      report_test("dbnz_loop", errs);

      // jump in the last word of a line, next fetch misses
      fill_background();
      place(16'h00, 16'h1010);
      place(16'h02, 16'h1020);
      place(16'h04, 16'h1030);
      place(16'h06, 16'h201C);
      place(16'h40, 16'h1040);
      place(16'h42, 16'hF000);
      errs = err_count;
      run_test("jump_in_miss", 8);
      report_test("jump_in_miss", errs);

      // halt with live code behind it, long wait
      fill_background();
      for (int i = 0; i < 7; i++) begin
         place(2 * i, alu_word($random(seed)));
      end
      place(16'h0E, 16'hF000);
      errs = err_count;
      run_test("halt_freeze", 200);
      report_test("halt_freeze", errs);

      // random alu words around two loops and a jump
      fill_background();
      for (int i = 0; i < 60; i++) begin
         place(2 * i, alu_word($random(seed)));
      end
      place(2, 16'h3003);
      place(20, 16'h4FF8);
      place(28, 16'h200F);
      place(66, 16'h3002);
      place(80, 16'h4FFA);
      place(90, 16'hF000);
      errs = err_count;
      run_test("random_mix", 8);
      report_test("random_mix", errs);

      $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
      if (err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- verilog.f
hw/fetch_pkg.sv
hw/inst_mem.sv
hw/fetch_unit.sv
hw/fetch_buffer.sv
hw/decode_branch.sv
hw/fetch_top.sv
dv/fetch_tb.sv

//--- Makefile
# Verilator build and run for the fetch front end

SIM      := verilator
FLAGS    := --binary --timing --assert
LINT     := --lint-only --timing -Wall
TOP      := fetch_tb
FILELIST := verilog.f
LOG      := sim.log
OBJ_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
